//--- hw/alu_pkg.sv
// ########################################
// alu slice shared types
// micro-ops, core operations, A/B sources
// ########################################
package alu_pkg;

    // default datapath width, one 6502 word
    parameter int DATA_W_DEF = 8;

    // micro-ops seen at the slice inputs
    typedef enum logic [2:0]
    {
        UOP_ADC     = 3'd0,
        UOP_SBC     = 3'd1,
        UOP_AND     = 3'd2,
        UOP_ORA     = 3'd3,
        UOP_EOR     = 3'd4,
        UOP_LSR     = 3'd5,
        UOP_INC_ADL = 3'd6,
        UOP_PASS_DB = 3'd7
    } alu_uop_e;

    // operations of the arithmetic logic
    typedef enum logic [2:0]
    {
        OP_SUM = 3'd0,
        OP_AND = 3'd1,
        OP_EOR = 3'd2,
        OP_OR  = 3'd3,
        OP_SR  = 3'd4
    } alu_op_e;

    // A input register sources, all ones when idle
    typedef enum logic [1:0] {A_ZERO, A_SB, A_ONES} a_src_e;

    // B input register sources, all ones when idle
    typedef enum logic [1:0] {B_DB, B_DB_N, B_ADL, B_ONES} b_src_e;

endpackage

//--- hw/alu_if.sv
// ########################################
// alu slice stage-to-stage interfaces
// ########################################
`timescale 1ns/1ns

// operand stage to core, decoded controls and bus values
interface alu_ctrl_if #(parameter int DATA_W = alu_pkg::DATA_W_DEF);
    logic                valid;
    alu_pkg::a_src_e     a_src;
    alu_pkg::b_src_e     b_src;
    alu_pkg::alu_op_e    op;
    logic                carry_in;
    logic [DATA_W-1:0]   sb;
    logic [DATA_W-1:0]   db;
    logic [DATA_W-1:0]   adl;

    modport src (output valid, a_src, b_src, op, carry_in, sb, db, adl);
    modport dst (input valid, a_src, b_src, op, carry_in, sb, db, adl);
endinterface

// core to result stage, hold register plus carry and overflow
interface alu_res_if #(parameter int DATA_W = alu_pkg::DATA_W_DEF);
    logic                valid;
    logic [DATA_W-1:0]   add;
    logic                acr;
    logic                avr;

    modport src (output valid, add, acr, avr);
    modport dst (input valid, add, acr, avr);
endinterface

//--- hw/alu_operand_stage.sv
// ########################################
// alu operand stage
// decodes a micro-op into core selects
// ########################################
`timescale 1ns/1ns

module alu_operand_stage #(
    parameter int DATA_W = alu_pkg::DATA_W_DEF
)(
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_strobe,
    input  alu_pkg::alu_uop_e    i_uop,
    input  logic                 i_c,
    input  logic [DATA_W-1:0]    i_sb,
    input  logic [DATA_W-1:0]    i_db,
    input  logic [DATA_W-1:0]    i_adl,
    alu_ctrl_if.src              o_ctrl
);

    alu_pkg::a_src_e     dec_a_src;
    alu_pkg::b_src_e     dec_b_src;
    alu_pkg::alu_op_e    dec_op;
    logic                dec_carry;

    // micro-op decode
    always_comb
    begin
        // logic ops take sb and db with no carry
        dec_a_src = alu_pkg::A_SB;
        dec_b_src = alu_pkg::B_DB;
        dec_op    = alu_pkg::OP_SUM;
        dec_carry = 1'b0;
        case (i_uop)
            alu_pkg::UOP_ADC:
            begin
                dec_carry = i_c;
            end
            alu_pkg::UOP_SBC:
            begin
                // subtract as sb + ~db + c
                dec_b_src = alu_pkg::B_DB_N;
                dec_carry = i_c;
            end
            alu_pkg::UOP_AND: dec_op = alu_pkg::OP_AND;
            alu_pkg::UOP_ORA: dec_op = alu_pkg::OP_OR;
            alu_pkg::UOP_EOR: dec_op = alu_pkg::OP_EOR;
            alu_pkg::UOP_LSR:
            begin
                // shifter only looks at B
                dec_op = alu_pkg::OP_SR;
            end
            alu_pkg::UOP_INC_ADL:
            begin
                // 0 + adl + 1
                dec_a_src = alu_pkg::A_ZERO;
                dec_b_src = alu_pkg::B_ADL;
                dec_carry = 1'b1;
            end
            default:
            begin
                // pass db through the adder
                dec_a_src = alu_pkg::A_ZERO;
            end
        endcase
    end

    // control register, idles at the all ones sources
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_ctrl.valid    <= 1'b0;
            o_ctrl.a_src    <= alu_pkg::A_ONES;
            o_ctrl.b_src    <= alu_pkg::B_ONES;
            o_ctrl.op       <= alu_pkg::OP_SUM;
            o_ctrl.carry_in <= 1'b0;
            o_ctrl.sb       <= '0;
            o_ctrl.db       <= '0;
            o_ctrl.adl      <= '0;
        end
        else if (i_strobe)
        begin
            o_ctrl.valid    <= 1'b1;
            o_ctrl.a_src    <= dec_a_src;
            o_ctrl.b_src    <= dec_b_src;
            o_ctrl.op       <= dec_op;
            o_ctrl.carry_in <= dec_carry;
            o_ctrl.sb       <= i_sb;
            o_ctrl.db       <= i_db;
            o_ctrl.adl      <= i_adl;
        end
        else
        begin
            // bus values hold, selects drop back
            o_ctrl.valid    <= 1'b0;
            o_ctrl.a_src    <= alu_pkg::A_ONES;
            o_ctrl.b_src    <= alu_pkg::B_ONES;
            o_ctrl.op       <= alu_pkg::OP_SUM;
            o_ctrl.carry_in <= 1'b0;
        end
    end

endmodule

//--- hw/alu_core.sv
// ########################################
// alu core
// A/B inputs, arithmetic logic, ADD hold
// ########################################
`timescale 1ns/1ns

module alu_core #(
    parameter int DATA_W = alu_pkg::DATA_W_DEF
)(
    input  logic        i_clk,
    input  logic        i_reset_n,
    alu_ctrl_if.dst     i_ctrl,
    alu_res_if.src      o_res
);

    logic [DATA_W-1:0]  a_in;
    logic [DATA_W-1:0]  b_in;
    logic [DATA_W:0]    sum_ext;
    logic [DATA_W-1:0]  alu_out;
    logic               alu_acr;
    logic               alu_avr;

    // B input register select
    always_comb
    begin
        case (i_ctrl.b_src)
            alu_pkg::B_DB:   b_in = i_ctrl.db;
            alu_pkg::B_DB_N: b_in = ~i_ctrl.db;
            alu_pkg::B_ADL:  b_in = i_ctrl.adl;
            default:         b_in = '1;
        endcase
    end

    // A input register select
    always_comb
    begin
        case (i_ctrl.a_src)
            alu_pkg::A_ZERO: a_in = '0;
            alu_pkg::A_SB:   a_in = i_ctrl.sb;
            default:         a_in = '1;
        endcase
    end

    // one extra bit catches the carry out
    assign sum_ext = {1'b0, a_in} + {1'b0, b_in} + {{DATA_W{1'b0}}, i_ctrl.carry_in};

    // arithmetic logic
    always_comb
    begin
        alu_out = '0;
        alu_acr = 1'b0;
        alu_avr = 1'b0;
        case (i_ctrl.op)
            alu_pkg::OP_SUM:
            begin
                alu_out = sum_ext[DATA_W-1:0];
                alu_acr = sum_ext[DATA_W];
                // same sign in, other sign out
                alu_avr = (a_in[DATA_W-1] == b_in[DATA_W-1]) &&
                          (sum_ext[DATA_W-1] != a_in[DATA_W-1]);
            end
            alu_pkg::OP_AND: alu_out = a_in & b_in;
            alu_pkg::OP_EOR: alu_out = a_in ^ b_in;
            alu_pkg::OP_OR:  alu_out = a_in | b_in;
            alu_pkg::OP_SR:
            begin
                // logical shift, lsb goes to carry
                alu_out = b_in >> 1;
                alu_acr = b_in[0];
            end
            default:
            begin
                alu_out = '0;
            end
        endcase
    end

    // adder hold register, loads only on a valid op
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_res.valid <= 1'b0;
            o_res.add   <= '0;
            o_res.acr   <= 1'b0;
            o_res.avr   <= 1'b0;
        end
        else
        begin
            o_res.valid <= i_ctrl.valid;
            if (i_ctrl.valid)
            begin
                o_res.add <= alu_out;
                o_res.acr <= alu_acr;
                o_res.avr <= alu_avr;
            end
        end
    end

endmodule

//--- hw/alu_result_stage.sv
// ########################################
// alu result stage
// result, N Z C V flags and done pulse
// ########################################
`timescale 1ns/1ns

module alu_result_stage #(
    parameter int DATA_W = alu_pkg::DATA_W_DEF
)(
    input  logic                i_clk,
    input  logic                i_reset_n,
    alu_res_if.dst              i_res,
    output logic [DATA_W-1:0]   o_result,
    output logic                o_n,
    output logic                o_z,
    output logic                o_c,
    output logic                o_v,
    output logic                o_done
);

    logic   flag_n;
    logic   flag_z;

    // sign from msb
    assign flag_n = i_res.add[DATA_W-1];
    // zero when no bit set
    assign flag_z = ~|i_res.add;

    // done follows valid by one edge
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_done <= 1'b0;
        end
        else
        begin
            o_done <= i_res.valid;
        end
    end

    // result and flags, held between ops
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_result <= '0;
            o_n      <= 1'b0;
            o_z      <= 1'b0;
            o_c      <= 1'b0;
            o_v      <= 1'b0;
        end
        else if (i_res.valid)
        begin
            o_result <= i_res.add;
            o_n      <= flag_n;
            o_z      <= flag_z;
            // carry and overflow come straight from the core
            o_c      <= i_res.acr;
            o_v      <= i_res.avr;
        end
    end

endmodule

//--- hw/alu_slice_top.sv
// ########################################
// alu slice top
// operand, core and result stages
// ########################################
`timescale 1ns/1ns

module alu_slice_top #(
    parameter int DATA_W = alu_pkg::DATA_W_DEF
)(
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_strobe,
    input  alu_pkg::alu_uop_e    i_uop,
    input  logic                 i_c,
    input  logic [DATA_W-1:0]    i_sb,
    input  logic [DATA_W-1:0]    i_db,
    input  logic [DATA_W-1:0]    i_adl,
    output logic [DATA_W-1:0]    o_result,
    output logic                 o_n,
    output logic                 o_z,
    output logic                 o_c,
    output logic                 o_v,
    output logic                 o_done
);

    // operand stage to core
    alu_ctrl_if #(.DATA_W(DATA_W)) ctrl_bus ();
    // core to result stage
    alu_res_if  #(.DATA_W(DATA_W)) res_bus ();

    // decode and capture on strobe, edge k+1
    alu_operand_stage #(.DATA_W(DATA_W)) u_operand (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_strobe  (i_strobe),
        .i_uop     (i_uop),
        .i_c       (i_c),
        .i_sb      (i_sb),
        .i_db      (i_db),
        .i_adl     (i_adl),
        .o_ctrl    (ctrl_bus.src)
    );

    // hold register loads at edge k+2
    alu_core #(.DATA_W(DATA_W)) u_core (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_ctrl    (ctrl_bus.dst),
        .o_res     (res_bus.src)
    );

    // flags and done at edge k+3
    alu_result_stage #(.DATA_W(DATA_W)) u_result (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_res     (res_bus.dst),
        .o_result  (o_result),
        .o_n       (o_n),
        .o_z       (o_z),
        .o_c       (o_c),
        .o_v       (o_v),
        .o_done    (o_done)
    );

endmodule

//--- dv/tb_alu_slice.sv
// ########################################
// alu slice testbench
// directed tests against a reference model
// ########################################
`timescale 1ns/1ns

module tb_alu_slice;

    localparam int DATA_W       = alu_pkg::DATA_W_DEF;
    localparam int DONE_TIMEOUT = 20;
    localparam int B2B_OPS      = 12;

    // expected value plus N Z C V
    typedef struct packed
    {
        logic [DATA_W-1:0] value;
        logic              n;
        logic              z;
        logic              c;
        logic              v;
    } exp_t;

    logic                i_clk = 1'b0;
    logic                i_reset_n;
    logic                i_strobe;
    alu_pkg::alu_uop_e   i_uop;
    logic                i_c;
    logic [DATA_W-1:0]   i_sb;
    logic [DATA_W-1:0]   i_db;
    logic [DATA_W-1:0]   i_adl;
    logic [DATA_W-1:0]   o_result;
    logic                o_n;
    logic                o_z;
    logic                o_c;
    logic                o_v;
    logic                o_done;

    logic [31:0]         lfsr_state = 32'h7784_b990;
    int                  value_errors = 0;
    int                  flag_errors = 0;
    int                  timing_errors = 0;
    int                  timeout_errors = 0;

    alu_slice_top #(.DATA_W(DATA_W)) uut (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_strobe(i_strobe), .i_uop(i_uop),
        .i_c(i_c), .i_sb(i_sb), .i_db(i_db), .i_adl(i_adl), .o_result(o_result),
        .o_n(o_n), .o_z(o_z), .o_c(o_c), .o_v(o_v), .o_done(o_done)
    );

    // 8 ns clock
    always #4 i_clk = ~i_clk;

    // galois lfsr, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            lfsr_next = (s >> 1) ^ 32'hA300_0000;
        else
            lfsr_next = s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected outputs from the micro-op rules
    function automatic exp_t model(input alu_pkg::alu_uop_e uop, input logic c,
                                   input logic [DATA_W-1:0] sb, db, adl);
        exp_t              e;
        logic [DATA_W-1:0] a_op;
        logic [DATA_W-1:0] b_op;
        logic              cin;
        logic              use_sum;
        int                total;
        int                signed_total;
        e       = '0;
        a_op    = '0;
        b_op    = '0;
        cin     = 1'b0;
        use_sum = 1'b1;
        case (uop)
            alu_pkg::UOP_ADC:
            begin
                a_op = sb;
                b_op = db;
                cin  = c;
            end
            alu_pkg::UOP_SBC:
            begin
                a_op = sb;
                b_op = ~db;
                cin  = c;
            end
            alu_pkg::UOP_AND:
            begin
                use_sum = 1'b0;
                e.value = sb & db;
            end
            alu_pkg::UOP_ORA:
            begin
                use_sum = 1'b0;
                e.value = sb | db;
            end
            alu_pkg::UOP_EOR:
            begin
                use_sum = 1'b0;
                e.value = sb ^ db;
            end
            alu_pkg::UOP_LSR:
            begin
                use_sum = 1'b0;
                e.value = db >> 1;
                e.c     = db[0];
            end
            alu_pkg::UOP_INC_ADL:
            begin
                b_op = adl;
                cin  = 1'b1;
            end
            default:
            begin
                b_op = db;
            end
        endcase
        if (use_sum)
        begin
            // unsigned total gives the carry, signed total the overflow
            total        = int'(a_op) + int'(b_op) + int'(cin);
            signed_total = int'($signed(a_op)) + int'($signed(b_op)) + int'(cin);
            e.value      = total[DATA_W-1:0];
            e.c          = (total >= (1 << DATA_W));
            e.v          = (signed_total >= (1 << (DATA_W - 1))) ||
                           (signed_total < -(1 << (DATA_W - 1)));
        end
        e.n = e.value[DATA_W-1];
        e.z = (e.value == '0);
        model = e;
    endfunction

    task automatic compare_value(input logic [DATA_W-1:0] got, exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %0t ns: %s result %h, expected %h", $time, what, got, exp);
        end
    endtask

    // flags packed as n z c v
    task automatic compare_flags(input logic [3:0] got, exp, input string what);
        if (got !== exp)
        begin
            flag_errors++;
            $display("[FAIL] %0t ns: %s nzcv %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input exp_t e, input string what);
        compare_value(o_result, e.value, what);
        compare_flags({o_n, o_z, o_c, o_v}, {e.n, e.z, e.c, e.v}, what);
    endtask

    // one strobe, then wait for done
    task automatic run_op(input alu_pkg::alu_uop_e uop, input logic c,
                          input logic [DATA_W-1:0] sb, db, adl, input string what);
        exp_t e;
        int   waited;
        logic seen;
        e = model(uop, c, sb, db, adl);
        @(posedge i_clk);
        i_strobe <= 1'b1;
        i_uop    <= uop;
        i_c      <= c;
        i_sb     <= sb;
        i_db     <= db;
        i_adl    <= adl;
        @(posedge i_clk);
        i_strobe <= 1'b0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < DONE_TIMEOUT)
        begin
            @(negedge i_clk);
            if (o_done)
                seen = 1'b1;
            else
                waited++;
        end
        if (!seen)
        begin
            timeout_errors++;
            $display("%0t ns: o_done never rose for %s", $time, what);
        end
        else
        begin
            check_result(e, what);
        end
    endtask

    task automatic test_reset();
        @(negedge i_clk);
        compare_value(o_result, '0, "reset");
        compare_flags({o_n, o_z, o_c, o_v}, 4'b0000, "reset");
        if (o_done !== 1'b0)
        begin
            timing_errors++;
            $display("[FAIL] %0t ns: reset o_done is %b", $time, o_done);
        end
    endtask

    task automatic test_arith();
        logic [31:0] r;
        run_op(alu_pkg::UOP_ADC, 1'b0, 8'h7f, 8'h01, 8'h00, "adc 7f+1");
        run_op(alu_pkg::UOP_ADC, 1'b1, 8'hff, 8'h01, 8'h00, "adc ff+1+c");
        run_op(alu_pkg::UOP_SBC, 1'b1, 8'h80, 8'h01, 8'h00, "sbc 80-1");
        run_op(alu_pkg::UOP_SBC, 1'b0, 8'h00, 8'h00, 8'h00, "sbc borrow");
        for (int i = 0; i < 40; i++)
        begin
            take_bits(2 * DATA_W + 1, r);
            run_op(alu_pkg::UOP_ADC, r[0], r[DATA_W:1], r[2*DATA_W:DATA_W+1], '0, "adc rand");
            run_op(alu_pkg::UOP_SBC, r[0], r[DATA_W:1], r[2*DATA_W:DATA_W+1], '0, "sbc rand");
        end
    endtask

    task automatic test_logic();
        logic [31:0] r;
        for (int i = 0; i < 10; i++)
        begin
            take_bits(2 * DATA_W, r);
            run_op(alu_pkg::UOP_AND, 1'b1, r[DATA_W-1:0], r[2*DATA_W-1:DATA_W], '0, "and");
            run_op(alu_pkg::UOP_ORA, 1'b1, r[DATA_W-1:0], r[2*DATA_W-1:DATA_W], '0, "ora");
            run_op(alu_pkg::UOP_EOR, 1'b1, r[DATA_W-1:0], r[2*DATA_W-1:DATA_W], '0, "eor");
        end
        // zero results for Z
        run_op(alu_pkg::UOP_AND, 1'b0, 8'h0f, 8'hf0, 8'h00, "and zero");
        run_op(alu_pkg::UOP_ORA, 1'b0, 8'h00, 8'h00, 8'h00, "ora zero");
        run_op(alu_pkg::UOP_EOR, 1'b0, 8'h5a, 8'h5a, 8'h00, "eor zero");
    endtask

    task automatic test_shift();
        logic [31:0] r;
        run_op(alu_pkg::UOP_LSR, 1'b1, 8'hff, 8'h01, 8'h00, "lsr 01");
        run_op(alu_pkg::UOP_LSR, 1'b0, 8'h00, 8'h80, 8'h00, "lsr 80");
        run_op(alu_pkg::UOP_LSR, 1'b0, 8'h00, 8'hff, 8'h00, "lsr ff");
        for (int i = 0; i < 8; i++)
        begin
            take_bits(2 * DATA_W, r);
            run_op(alu_pkg::UOP_LSR, 1'b1, r[DATA_W-1:0], r[2*DATA_W-1:DATA_W], '0, "lsr rand");
        end
    endtask

    // sb carries noise, A must be zero
    task automatic test_zero_a();
        logic [31:0] r;
        run_op(alu_pkg::UOP_INC_ADL, 1'b0, 8'h55, 8'h00, 8'hff, "inc adl ff");
        run_op(alu_pkg::UOP_INC_ADL, 1'b0, 8'haa, 8'h00, 8'h7f, "inc adl 7f");
        run_op(alu_pkg::UOP_PASS_DB, 1'b1, 8'hff, 8'h00, 8'h00, "pass 00");
        run_op(alu_pkg::UOP_PASS_DB, 1'b1, 8'hff, 8'h80, 8'h00, "pass 80");
        for (int i = 0; i < 6; i++)
        begin
            take_bits(3 * DATA_W, r);
            run_op(alu_pkg::UOP_INC_ADL, 1'b0, r[DATA_W-1:0], '0, r[2*DATA_W-1:DATA_W],
                   "inc rand");
            run_op(alu_pkg::UOP_PASS_DB, 1'b1, r[DATA_W-1:0], r[3*DATA_W-1:2*DATA_W], '0,
                   "pass rand");
        end
    endtask

    // strobe every cycle, done three edges after each drive edge
    task automatic test_back_to_back();
        exp_t              exp_q[$];
        int                due_q[$];
        logic [31:0]       r;
        alu_pkg::alu_uop_e uop;
        int                cycle;
        int                issued;
        exp_t              e;
        cycle  = 0;
        issued = 0;
        while ((issued < B2B_OPS || exp_q.size() > 0) && cycle < B2B_OPS + DONE_TIMEOUT)
        begin
            @(posedge i_clk);
            cycle++;
            if (issued < B2B_OPS)
            begin
                take_bits(3 + 3 * DATA_W + 1, r);
                uop = alu_pkg::alu_uop_e'(r[2:0]);
                i_strobe <= 1'b1;
                i_uop    <= uop;
                i_c      <= r[3];
                i_sb     <= r[DATA_W+3:4];
                i_db     <= r[2*DATA_W+3:DATA_W+4];
                i_adl    <= r[3*DATA_W+3:2*DATA_W+4];
                exp_q.push_back(model(uop, r[3], r[DATA_W+3:4], r[2*DATA_W+3:DATA_W+4],
                                      r[3*DATA_W+3:2*DATA_W+4]));
                due_q.push_back(cycle + 3);
                issued++;
            end
            else
            begin
                i_strobe <= 1'b0;
            end
            @(negedge i_clk);
            if (o_done)
            begin
                if (exp_q.size() == 0)
                begin
                    timing_errors++;
                    $display("%0t ns: o_done rose with no operation outstanding", $time);
                end
                else
                begin
                    e = exp_q.pop_front();
                    if (due_q.pop_front() != cycle)
                    begin
                        timing_errors++;
                        $display("[FAIL] %0t ns: back-to-back done at wrong cycle", $time);
                    end
                    check_result(e, "back-to-back");
                end
            end
            else if (due_q.size() > 0 && due_q[0] <= cycle)
            begin
                // missed pulse, drop it and keep going
                timing_errors++;
                $display("[FAIL] %0t ns: back-to-back o_done missing", $time);
                e = exp_q.pop_front();
                void'(due_q.pop_front());
            end
        end
        if (exp_q.size() > 0)
        begin
            timeout_errors++;
            $display("%0t ns: back-to-back ops still outstanding at timeout", $time);
        end
        else
        begin
            // one pulse per op, so done falls after the last one
            @(negedge i_clk);
            if (o_done)
            begin
                timing_errors++;
                $display("[FAIL] %0t ns: o_done held after the last operation", $time);
            end
        end
    endtask

    initial
    begin
        i_reset_n <= 1'b0;
        i_strobe  <= 1'b0;
        i_uop     <= alu_pkg::UOP_ADC;
        i_c       <= 1'b0;
        i_sb      <= '0;
        i_db      <= '0;
        i_adl     <= '0;
        repeat (4) @(posedge i_clk);
        i_reset_n <= 1'b1;
        test_reset();
        test_arith();
        test_logic();
        test_shift();
        test_zero_a();
        test_back_to_back();
        $display("errors: value %0d, flags %0d, timing %0d, timeout %0d",
                 value_errors, flag_errors, timing_errors, timeout_errors);
        if (value_errors + flag_errors + timing_errors + timeout_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- alu_slice.f
hw/alu_pkg.sv
hw/alu_if.sv
hw/alu_operand_stage.sv
hw/alu_core.sv
hw/alu_result_stage.sv
hw/alu_slice_top.sv
dv/tb_alu_slice.sv

//--- run_sim.sh
#!/bin/sh
# build and run the alu slice testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_alu_slice -f alu_slice.f -o sim_alu_slice
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_alu_slice > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

exit 0
